// ==== Makefile ====
TOP := tb_reservation_station

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== common/core_types_pkg.sv ====
`include "rs_macros.svh"

package core_types_pkg;

    // renamed register tag, also what the broadcast buses carry
    typedef logic [`PREG_BITS-1:0] preg_t;

    // x0..x31
    typedef logic [`AREG_BITS-1:0] areg_t;

    // slot in the reorder buffer
    typedef logic [`ROB_BITS-1:0] rob_idx_t;

endpackage

// ==== common/rs_macros.svh ====
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// bank sizes
`define RS_ADD_ENTRIES 8
`define RS_MUL_ENTRIES 4

// physical register tag, 64 pregs
`define PREG_BITS 6

// rv32 architectural register number
`define AREG_BITS 5

// rob index, must track rob depth
`define ROB_BITS 6

`endif

// ==== common/rs_pkg.sv ====
package rs_pkg;

    // which bank a dispatched instruction goes to
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_kind_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1, // signed x signed, upper half
        MUL_MULHSU = 2'd2, // signed x unsigned
        MUL_MULHU  = 2'd3
    } mul_op_t;

    // one station slot, op code lives in a separate array per bank
    typedef struct packed {
        logic                     busy;    // slot holds a live instruction
        core_types_pkg::preg_t    ps1;
        logic                     ps1_rdy;
        core_types_pkg::preg_t    ps2;
        logic                     ps2_rdy;
        core_types_pkg::preg_t    pd;
        core_types_pkg::areg_t    rd;
        core_types_pkg::rob_idx_t rob_idx;
    } rs_entry_t;

endpackage

// ==== dv/rs_props.sv ====
`timescale 1ns/1ps

module rs_props (
    input logic clk,
    input logic rst,
    input logic alu_busy,
    input logic mul_busy,
    input logic alu_issue_valid,
    input logic mul_issue_valid,
    input logic add_full,
    input logic mul_full
);

    alu_hold: assert property (@(posedge clk) disable iff (rst) alu_busy |-> !alu_issue_valid)
        else $error("alu issue valid while alu_busy is high");

    mul_hold: assert property (@(posedge clk) disable iff (rst) mul_busy |-> !mul_issue_valid)
        else $error("mul issue valid while mul_busy is high");

    // banks come out of reset empty
    quiet_after_rst: assert property (@(posedge clk) rst |=> !(alu_issue_valid || mul_issue_valid))
        else $error("issue valid in the cycle after reset");

    empty_after_rst: assert property (@(posedge clk) rst |=> !(add_full || mul_full))
        else $error("full flag high in the cycle after reset");

endmodule

bind reservation_station rs_props rs_props_inst (
    .clk (clk), .rst (rst), .alu_busy (alu_busy), .mul_busy (mul_busy),
    .alu_issue_valid (alu_issue_valid), .mul_issue_valid (mul_issue_valid),
    .add_full (add_full), .mul_full (mul_full)
);

// ==== dv/tb_reservation_station.sv ====
`timescale 1ns/1ps
`include "rs_macros.svh"

module tb_reservation_station;
    import core_types_pkg::*;
    import rs_pkg::*;

    localparam int NA         = `RS_ADD_ENTRIES;
    localparam int NM         = `RS_MUL_ENTRIES;
    localparam int MAX_CYCLES = 3000; // ~100 directed plus 2000 random cycles

    logic     clk = 1'b0;
    logic     rst;
    logic     dispatch_valid, dispatch_ps1_rdy, dispatch_ps2_rdy;
    fu_kind_t dispatch_fu;
    preg_t    dispatch_ps1, dispatch_ps2, dispatch_pd;
    areg_t    dispatch_rd;
    rob_idx_t dispatch_rob_idx;
    alu_op_t  dispatch_alu_op;
    mul_op_t  dispatch_mul_op;
    logic     alu_bcast_valid, mul_bcast_valid, alu_busy, mul_busy;
    preg_t    alu_bcast_tag, mul_bcast_tag;
    logic     add_full, mul_full, alu_issue_valid, mul_issue_valid;
    preg_t    alu_issue_ps1, alu_issue_ps2, alu_issue_pd;
    preg_t    mul_issue_ps1, mul_issue_ps2, mul_issue_pd;
    areg_t    alu_issue_rd, mul_issue_rd;
    rob_idx_t alu_issue_rob_idx, mul_issue_rob_idx;
    alu_op_t  alu_issue_op;
    mul_op_t  mul_issue_op;

    rs_entry_t   m_ent [NA+NM]; // model slots, alu bank first
    logic [2:0]  m_op  [NA+NM];
    int          cycles     = 0;
    int          rob_ctr    = 0;

    reservation_station reservation_station_inst (.*);

    always #4 clk = ~clk;

    function automatic logic bcast_match(input preg_t tag);
        return (alu_bcast_valid && alu_bcast_tag == tag) ||
               (mul_bcast_valid && mul_bcast_tag == tag);
    endfunction

    // lowest free slot, or lowest slot with both sources ready, -1 if none
    function automatic int lowest_slot(input int base, input int depth, input bit want_ready);
        for (int i = base; i < base + depth; i++)
        begin
            if (want_ready ? (m_ent[i].busy && m_ent[i].ps1_rdy && m_ent[i].ps2_rdy)
                           : !m_ent[i].busy)
            begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int expected_issue(input int base, input int depth, input logic fu_busy);
        return fu_busy ? -1 : lowest_slot(base, depth, 1'b1);
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_alu_issue(input logic v, input rs_entry_t e, input alu_op_t op);
        if (alu_issue_valid !== v || alu_issue_ps1 !== e.ps1 || alu_issue_ps2 !== e.ps2 ||
            alu_issue_pd !== e.pd || alu_issue_rd !== e.rd || alu_issue_rob_idx !== e.rob_idx ||
            alu_issue_op !== op)
        begin
            mismatch($sformatf("alu issue v=%0b rob=%0d op=%0d, expected v=%0b rob=%0d op=%0d",
                alu_issue_valid, alu_issue_rob_idx, alu_issue_op, v, e.rob_idx, op));
        end
    endtask

    task automatic check_mul_issue(input logic v, input rs_entry_t e, input mul_op_t op);
        if (mul_issue_valid !== v || mul_issue_ps1 !== e.ps1 || mul_issue_ps2 !== e.ps2 ||
            mul_issue_pd !== e.pd || mul_issue_rd !== e.rd || mul_issue_rob_idx !== e.rob_idx ||
            mul_issue_op !== op)
        begin
            mismatch($sformatf("mul issue v=%0b rob=%0d op=%0d, expected v=%0b rob=%0d op=%0d",
                mul_issue_valid, mul_issue_rob_idx, mul_issue_op, v, e.rob_idx, op));
        end
    endtask

    task automatic check_full(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatch($sformatf("%s is %0b, expected %0b", name, got, exp));
        end
    endtask

    // compare before the edge, then advance the model
    always @(posedge clk)
    begin
        int        ai, mi, fa, fm, slot;
        rs_entry_t ea, em;
        alu_op_t   aop;
        mul_op_t   mop;
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
        if (rst)
        begin
            for (int i = 0; i < NA + NM; i++)
            begin
                m_ent[i].busy = 1'b0;
            end
        end
        else
        begin
            ai  = expected_issue(0, NA, alu_busy);
            mi  = expected_issue(NA, NM, mul_busy);
            fa  = lowest_slot(0, NA, 1'b0);
            fm  = lowest_slot(NA, NM, 1'b0);
            ea  = '0;
            em  = '0;
            aop = ALU_ADD;
            mop = MUL_MUL;
            if (ai >= 0)
            begin
                ea  = m_ent[ai];
                aop = alu_op_t'(m_op[ai]);
            end
            if (mi >= 0)
            begin
                em  = m_ent[mi];
                mop = mul_op_t'(m_op[mi][1:0]);
            end
            check_alu_issue(ai >= 0, ea, aop);
            check_mul_issue(mi >= 0, em, mop);
            check_full("add_full", add_full, fa < 0);
            check_full("mul_full", mul_full, fm < 0);
            for (int i = 0; i < NA + NM; i++)
            begin
                if (bcast_match(m_ent[i].ps1)) m_ent[i].ps1_rdy = 1'b1;
                if (bcast_match(m_ent[i].ps2)) m_ent[i].ps2_rdy = 1'b1;
            end
            if (ai >= 0) m_ent[ai].busy = 1'b0;
            if (mi >= 0) m_ent[mi].busy = 1'b0;
            slot = (dispatch_fu == FU_ALU) ? fa : fm; // free search on pre-edge busy bits
            if (dispatch_valid && slot >= 0)
            begin
                m_ent[slot] = '{busy: 1'b1, ps1: dispatch_ps1,
                    ps1_rdy: dispatch_ps1_rdy || bcast_match(dispatch_ps1),
                    ps2: dispatch_ps2, ps2_rdy: dispatch_ps2_rdy || bcast_match(dispatch_ps2),
                    pd: dispatch_pd, rd: dispatch_rd, rob_idx: dispatch_rob_idx};
                m_op[slot] = (dispatch_fu == FU_ALU) ? 3'(dispatch_alu_op)
                                                     : {1'b0, dispatch_mul_op};
            end
        end
    end

    task automatic step(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_idle();
        {dispatch_valid, dispatch_ps1_rdy, dispatch_ps2_rdy, alu_busy, mul_busy} = '0;
        {dispatch_ps1, dispatch_ps2, dispatch_pd, dispatch_rd, dispatch_rob_idx} = '0;
        {alu_bcast_valid, alu_bcast_tag, mul_bcast_valid, mul_bcast_tag} = '0;
        dispatch_fu     = FU_ALU;
        dispatch_alu_op = ALU_ADD;
        dispatch_mul_op = MUL_MUL;
    endtask

    task automatic dispatch(input fu_kind_t fu, input int ps1, input logic r1, input int ps2,
                            input logic r2, input int op);
        dispatch_valid   = 1'b1;
        dispatch_fu      = fu;
        dispatch_ps1     = preg_t'(ps1);
        dispatch_ps1_rdy = r1;
        dispatch_ps2     = preg_t'(ps2);
        dispatch_ps2_rdy = r2;
        dispatch_pd      = preg_t'(rob_ctr + 1);
        dispatch_rd      = areg_t'(rob_ctr);
        dispatch_rob_idx = rob_idx_t'(rob_ctr);
        dispatch_alu_op  = alu_op_t'(op % 6);
        dispatch_mul_op  = mul_op_t'(op % 4);
        rob_ctr++;
        step(1);
        dispatch_valid = 1'b0;
    endtask

    // wait for the issue handshakes to go quiet
    task automatic wait_drain();
        step(1);
        while (alu_issue_valid || mul_issue_valid) step(1);
    endtask

    initial
    begin
        void'($urandom(32'h63b4_9361));
        set_idle();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 4; i++) dispatch(fu_kind_t'(i % 2), i, 1'b1, i + 8, 1'b1, i);
        wait_drain();
        // fill alu bank with waiting entries, one extra is dropped
        for (int i = 0; i < NA; i++) dispatch(FU_ALU, 32 + i, 1'b0, 40 + i, 1'b0, i);
        dispatch(FU_ALU, 60, 1'b1, 61, 1'b1, 0);
        if (!add_full)
        begin
            $display("add_full stayed low with every ALU entry in use");
            abort_run();
        end
        dispatch(FU_MUL, 48, 1'b0, 49, 1'b0, 1);
        for (int t = 32; t < 50; t += 2)
        begin
            {alu_bcast_valid, mul_bcast_valid} = 2'b11;
            alu_bcast_tag = preg_t'(t);
            mul_bcast_tag = preg_t'(t + 1);
            step(1);
        end
        {alu_bcast_valid, mul_bcast_valid} = 2'b00;
        wait_drain();
        {alu_busy, mul_busy} = 2'b11; // back-pressure
        for (int i = 0; i < 7; i++) dispatch(i < 4 ? FU_ALU : FU_MUL, i, 1'b1, i, 1'b1, i);
        step(3);
        {alu_busy, mul_busy} = 2'b00;
        wait_drain();
        alu_bcast_valid = 1'b1; // same-cycle bypass
        alu_bcast_tag   = preg_t'(20);
        dispatch(FU_ALU, 20, 1'b0, 5, 1'b1, 3);
        alu_bcast_valid = 1'b0;
        mul_bcast_valid = 1'b1;
        mul_bcast_tag   = preg_t'(21);
        dispatch(FU_MUL, 9, 1'b1, 21, 1'b0, 2);
        mul_bcast_valid = 1'b0;
        wait_drain();
        for (int c = 0; c < 2000; c++)
        begin
            dispatch_valid   = ($urandom % 3) != 0;
            dispatch_fu      = fu_kind_t'($urandom % 2);
            dispatch_ps1     = preg_t'($urandom % 8); // small tag pool
            dispatch_ps1_rdy = ($urandom % 4) == 0;
            dispatch_ps2     = preg_t'($urandom % 8);
            dispatch_ps2_rdy = ($urandom % 4) == 0;
            dispatch_pd      = preg_t'($urandom);
            dispatch_rd      = areg_t'($urandom);
            dispatch_rob_idx = rob_idx_t'($urandom);
            dispatch_alu_op  = alu_op_t'($urandom % 6);
            dispatch_mul_op  = mul_op_t'($urandom % 4);
            alu_bcast_valid  = ($urandom % 3) == 0;
            alu_bcast_tag    = preg_t'($urandom % 8);
            mul_bcast_valid  = ($urandom % 3) == 0;
            mul_bcast_tag    = preg_t'($urandom % 8);
            alu_busy         = ($urandom % 4) == 0;
            mul_busy         = ($urandom % 4) == 0;
            step(1);
        end
        set_idle();
        wait_drain();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps
`include "rs_macros.svh"

module reservation_station (
    input  logic                     clk,
    input  logic                     rst,
    // dispatch from rename
    input  logic                     dispatch_valid,
    input  rs_pkg::fu_kind_t         dispatch_fu,
    input  core_types_pkg::preg_t    dispatch_ps1,
    input  logic                     dispatch_ps1_rdy,
    input  core_types_pkg::preg_t    dispatch_ps2,
    input  logic                     dispatch_ps2_rdy,
    input  core_types_pkg::preg_t    dispatch_pd,
    input  core_types_pkg::areg_t    dispatch_rd,
    input  core_types_pkg::rob_idx_t dispatch_rob_idx,
    input  rs_pkg::alu_op_t          dispatch_alu_op,
    input  rs_pkg::mul_op_t          dispatch_mul_op,
    // completion broadcasts
    input  logic                     alu_bcast_valid,
    input  core_types_pkg::preg_t    alu_bcast_tag,
    input  logic                     mul_bcast_valid,
    input  core_types_pkg::preg_t    mul_bcast_tag,
    // fu back-pressure
    input  logic                     alu_busy,
    input  logic                     mul_busy,
    output logic                     add_full,
    output logic                     mul_full,
    // alu issue
    output logic                     alu_issue_valid,
    output core_types_pkg::preg_t    alu_issue_ps1,
    output core_types_pkg::preg_t    alu_issue_ps2,
    output core_types_pkg::preg_t    alu_issue_pd,
    output core_types_pkg::areg_t    alu_issue_rd,
    output core_types_pkg::rob_idx_t alu_issue_rob_idx,
    output rs_pkg::alu_op_t          alu_issue_op,
    // mul issue
    output logic                     mul_issue_valid,
    output core_types_pkg::preg_t    mul_issue_ps1,
    output core_types_pkg::preg_t    mul_issue_ps2,
    output core_types_pkg::preg_t    mul_issue_pd,
    output core_types_pkg::areg_t    mul_issue_rd,
    output core_types_pkg::rob_idx_t mul_issue_rob_idx,
    output rs_pkg::mul_op_t          mul_issue_op
);
    import rs_pkg::*;

    logic add_wr_req;
    logic mul_wr_req;

    // steer to one bank, each bank checks its own full flag
    assign add_wr_req = dispatch_valid && (dispatch_fu == FU_ALU);
    assign mul_wr_req = dispatch_valid && (dispatch_fu == FU_MUL);

    rs_bank #(
        .payload_t (alu_op_t),
        .DEPTH     (`RS_ADD_ENTRIES)
    ) add_bank (
        .clk           (clk),
        .rst           (rst),
        .wr_req        (add_wr_req),
        .wr_ps1        (dispatch_ps1),
        .wr_ps1_rdy    (dispatch_ps1_rdy),
        .wr_ps2        (dispatch_ps2),
        .wr_ps2_rdy    (dispatch_ps2_rdy),
        .wr_pd         (dispatch_pd),
        .wr_rd         (dispatch_rd),
        .wr_rob_idx    (dispatch_rob_idx),
        .wr_op         (dispatch_alu_op),
        .bcast_a_valid (alu_bcast_valid),
        .bcast_a_tag   (alu_bcast_tag),
        .bcast_b_valid (mul_bcast_valid),
        .bcast_b_tag   (mul_bcast_tag),
        .fu_busy       (alu_busy),
        .full          (add_full),
        .issue_valid   (alu_issue_valid),
        .issue_ps1     (alu_issue_ps1),
        .issue_ps2     (alu_issue_ps2),
        .issue_pd      (alu_issue_pd),
        .issue_rd      (alu_issue_rd),
        .issue_rob_idx (alu_issue_rob_idx),
        .issue_op      (alu_issue_op)
    );

    rs_bank #(
        .payload_t (mul_op_t),
        .DEPTH     (`RS_MUL_ENTRIES)
    ) mul_bank (
        .clk           (clk),
        .rst           (rst),
        .wr_req        (mul_wr_req),
        .wr_ps1        (dispatch_ps1),
        .wr_ps1_rdy    (dispatch_ps1_rdy),
        .wr_ps2        (dispatch_ps2),
        .wr_ps2_rdy    (dispatch_ps2_rdy),
        .wr_pd         (dispatch_pd),
        .wr_rd         (dispatch_rd),
        .wr_rob_idx    (dispatch_rob_idx),
        .wr_op         (dispatch_mul_op),
        .bcast_a_valid (alu_bcast_valid),
        .bcast_a_tag   (alu_bcast_tag),
        .bcast_b_valid (mul_bcast_valid),
        .bcast_b_tag   (mul_bcast_tag),
        .fu_busy       (mul_busy),
        .full          (mul_full),
        .issue_valid   (mul_issue_valid),
        .issue_ps1     (mul_issue_ps1),
        .issue_ps2     (mul_issue_ps2),
        .issue_pd      (mul_issue_pd),
        .issue_rd      (mul_issue_rd),
        .issue_rob_idx (mul_issue_rob_idx),
        .issue_op      (mul_issue_op)
    );

endmodule

// ==== project.f ====
+incdir+common
common/core_types_pkg.sv
common/rs_pkg.sv
rs_bank/entry_picker.sv
rs_bank/rs_bank.sv
hw/reservation_station.sv
dv/rs_props.sv
dv/tb_reservation_station.sv

// ==== rs_bank/entry_picker.sv ====
`timescale 1ns/1ps

module entry_picker #(
    parameter int N = 4
) (
    input  logic [N-1:0]         req,
    output logic                 found,
    output logic [$clog2(N)-1:0] idx
);
    localparam int IDX_BITS = $clog2(N);

    always_comb
    begin
        found = |req;
        idx   = '0;
        // walk down so the lowest set bit wins
        for (int i = N - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                idx = IDX_BITS'(i);
            end
        end
    end

endmodule

// ==== rs_bank/rs_bank.sv ====
`timescale 1ns/1ps

module rs_bank #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_req,
    input  core_types_pkg::preg_t    wr_ps1,
    input  logic                     wr_ps1_rdy,
    input  core_types_pkg::preg_t    wr_ps2,
    input  logic                     wr_ps2_rdy,
    input  core_types_pkg::preg_t    wr_pd,
    input  core_types_pkg::areg_t    wr_rd,
    input  core_types_pkg::rob_idx_t wr_rob_idx,
    input  payload_t                 wr_op,
    input  logic                     bcast_a_valid,
    input  core_types_pkg::preg_t    bcast_a_tag,
    input  logic                     bcast_b_valid,
    input  core_types_pkg::preg_t    bcast_b_tag,
    input  logic                     fu_busy,
    output logic                     full,
    output logic                     issue_valid,
    output core_types_pkg::preg_t    issue_ps1,
    output core_types_pkg::preg_t    issue_ps2,
    output core_types_pkg::preg_t    issue_pd,
    output core_types_pkg::areg_t    issue_rd,
    output core_types_pkg::rob_idx_t issue_rob_idx,
    output payload_t                 issue_op
);
    import core_types_pkg::*;
    import rs_pkg::*;

    localparam int IDX_BITS = $clog2(DEPTH);

    rs_entry_t entries [DEPTH];
    payload_t  ops     [DEPTH]; // op code per slot

    logic [DEPTH-1:0]    busy_vec;
    logic [DEPTH-1:0]    ready_vec;
    logic                free_found;
    logic [IDX_BITS-1:0] free_idx;
    logic                ready_found;
    logic [IDX_BITS-1:0] ready_idx;
    logic                accept;

    // true when either bus completes this tag in the current cycle
    function automatic logic bcast_hit(input preg_t tag);
        return (bcast_a_valid && (bcast_a_tag == tag)) ||
               (bcast_b_valid && (bcast_b_tag == tag));
    endfunction

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            busy_vec[i]  = entries[i].busy;
            ready_vec[i] = entries[i].busy && entries[i].ps1_rdy && entries[i].ps2_rdy;
        end
    end

    entry_picker #(.N(DEPTH)) free_pick (
        .req   (~busy_vec),
        .found (free_found),
        .idx   (free_idx)
    );

    entry_picker #(.N(DEPTH)) ready_pick (
        .req   (ready_vec),
        .found (ready_found),
        .idx   (ready_idx)
    );

    assign full        = ~free_found; // every slot busy
    assign accept      = wr_req && ~full;
    assign issue_valid = ready_found && ~fu_busy;

    // zeroed when nothing issues
    assign issue_ps1     = issue_valid ? entries[ready_idx].ps1 : '0;
    assign issue_ps2     = issue_valid ? entries[ready_idx].ps2 : '0;
    assign issue_pd      = issue_valid ? entries[ready_idx].pd : '0;
    assign issue_rd      = issue_valid ? entries[ready_idx].rd : '0;
    assign issue_rob_idx = issue_valid ? entries[ready_idx].rob_idx : '0;
    assign issue_op      = issue_valid ? ops[ready_idx] : payload_t'(0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                entries[i].busy <= 1'b0;
            end
        end
        else
        begin
            // wakeup of stored sources
            for (int i = 0; i < DEPTH; i++)
            begin
                if (bcast_hit(entries[i].ps1))
                begin
                    entries[i].ps1_rdy <= 1'b1;
                end
                if (bcast_hit(entries[i].ps2))
                begin
                    entries[i].ps2_rdy <= 1'b1;
                end
            end

            if (issue_valid)
            begin
                entries[ready_idx].busy <= 1'b0; // fu takes it this cycle
            end

            // free slot is never the issuing one, so no overlap here
            if (accept)
            begin
                entries[free_idx] <= '{
                    busy:    1'b1,
                    ps1:     wr_ps1,
                    ps1_rdy: wr_ps1_rdy || bcast_hit(wr_ps1),
                    ps2:     wr_ps2,
                    ps2_rdy: wr_ps2_rdy || bcast_hit(wr_ps2),
                    pd:      wr_pd,
                    rd:      wr_rd,
                    rob_idx: wr_rob_idx
                };
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ops[free_idx] <= wr_op;
        end
    end

endmodule
